//--- design/exec_pkg.sv
package exec_pkg;

  // ==============================
  // widths
  // ==============================
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [XLEN-1:0]       xlen_t;      // data word, operands and PCs
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;  // register index

  localparam xlen_t PC_STEP = 32'd4;  // link increment

  // ==============================
  // control encodings
  // ==============================
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_LUI,
    ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
    ALU_JAL, ALU_JALR,
    ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU,
    ALU_SB, ALU_SH, ALU_SW
  } alu_code_e;

  typedef enum logic [1:0] {
    OP1_RS1,
    OP1_PC,
    OP1_ZERO
  } op1_sel_e;

  typedef enum logic {
    OP2_RS2,
    OP2_IMM
  } op2_sel_e;

  typedef enum logic [1:0] {
    MEM_BYTE,
    MEM_HALF,
    MEM_WORD
  } mem_width_e;

  // ==============================
  // pipeline structs
  // ==============================
  typedef struct packed {
    alu_code_e alu_code;
    op1_sel_e  op1_sel;
    op2_sel_e  op2_sel;
  } alu_ctrl_t;

  typedef struct packed {
    logic      we;    // rd write enable
    reg_addr_t addr;
  } rd_ctrl_t;

  // decode -> execute
  typedef struct packed {
    xlen_t     pc;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    xlen_t     imm;
    alu_ctrl_t alu_ctrl;
    rd_ctrl_t  rd_ctrl;
    logic      is_load;
    logic      is_store;
  } dec_exe_t;

  // execute -> memory
  typedef struct packed {
    xlen_t      pc;
    xlen_t      alu_result;
    xlen_t      w_data;
    mem_width_e mem_width;
    rd_ctrl_t   rd_ctrl;
    logic       is_load;
    logic       is_store;
    logic       is_load_unsigned;
  } exe_mem_t;

  // conditional branch codes, shared by operand muxing and the alu
  function automatic logic is_branch_code(alu_code_e code);
    case (code)
      ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage

//--- design/operand_select.sv
module operand_select import exec_pkg::*; (
  input  alu_ctrl_t ctrl,
  input  xlen_t     pc,
  input  xlen_t     rs1,
  input  xlen_t     rs2,
  input  xlen_t     imm,
  output xlen_t     alu_op1,
  output xlen_t     alu_op2,
  output xlen_t     npc_op1,
  output xlen_t     npc_op2
);

  logic branch_op;

  assign branch_op = is_branch_code(ctrl.alu_code);

  // ==============================
  // alu operands
  // ==============================
  always_comb begin
    if (branch_op) begin
      // compare needs both registers, imm goes to the target adder
      alu_op1 = rs1;
      alu_op2 = rs2;
    end else begin
      case (ctrl.op1_sel)
        OP1_RS1: alu_op1 = rs1;
        OP1_PC:  alu_op1 = pc;
        default: alu_op1 = '0;
      endcase

      case (ctrl.op2_sel)
        OP2_IMM: alu_op2 = imm;
        default: alu_op2 = rs2;
      endcase
    end
  end

  // ==============================
  // next-pc operands
  // ==============================
  always_comb begin
    if (ctrl.alu_code == ALU_JALR) begin
      npc_op1 = rs1;  // register-relative jump
    end else begin
      npc_op1 = pc;
    end
    npc_op2 = imm;
  end

endmodule

//--- design/alu.sv
module alu import exec_pkg::*; (
  input  alu_code_e  alu_code,
  input  xlen_t      op1,
  input  xlen_t      op2,
  input  xlen_t      pc,
  output xlen_t      alu_result,
  output logic       is_branch,
  output logic       br_taken,
  output mem_width_e mem_width,
  output logic       is_load_unsigned
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;
  xlen_t      addr;

  assign shamt = op2[4:0];  // only low 5 bits count
  assign lt_s  = $signed(op1) < $signed(op2);
  assign lt_u  = op1 < op2;
  assign eq    = op1 == op2;
  assign addr  = op1 + op2;

  assign is_branch = is_branch_code(alu_code);

  always_comb begin
    alu_result       = '0;
    br_taken         = 1'b0;
    mem_width        = MEM_WORD;
    is_load_unsigned = 1'b0;

    case (alu_code)
      // ==============================
      // integer ops
      // ==============================
      ALU_ADD:  alu_result = op1 + op2;
      ALU_SUB:  alu_result = op1 - op2;
      ALU_SLT:  alu_result = xlen_t'(lt_s);
      ALU_SLTU: alu_result = xlen_t'(lt_u);
      ALU_XOR:  alu_result = op1 ^ op2;
      ALU_OR:   alu_result = op1 | op2;
      ALU_AND:  alu_result = op1 & op2;
      ALU_SLL:  alu_result = op1 << shamt;
      ALU_SRL:  alu_result = op1 >> shamt;
      ALU_SRA:  alu_result = xlen_t'($signed(op1) >>> shamt);
      ALU_LUI:  alu_result = op2;  // imm already shifted by decode

      // ==============================
      // branches, result stays zero
      // ==============================
      ALU_BEQ:  br_taken = eq;
      ALU_BNE:  br_taken = !eq;
      ALU_BLT:  br_taken = lt_s;
      ALU_BGE:  br_taken = !lt_s;
      ALU_BLTU: br_taken = lt_u;
      ALU_BGEU: br_taken = !lt_u;

      // link address
      ALU_JAL, ALU_JALR: alu_result = pc + PC_STEP;

      // ==============================
      // loads and stores
      // ==============================
      ALU_LB, ALU_SB: begin
        alu_result = addr;
        mem_width  = MEM_BYTE;
      end
      ALU_LH, ALU_SH: begin
        alu_result = addr;
        mem_width  = MEM_HALF;
      end
      ALU_LW, ALU_SW: begin
        alu_result = addr;
        mem_width  = MEM_WORD;
      end
      ALU_LBU: begin
        alu_result       = addr;
        mem_width        = MEM_BYTE;
        is_load_unsigned = 1'b1;
      end
      ALU_LHU: begin
        alu_result       = addr;
        mem_width        = MEM_HALF;
        is_load_unsigned = 1'b1;
      end

      default: alu_result = '0;
    endcase
  end

endmodule

//--- design/branch_unit.sv
module branch_unit import exec_pkg::*; (
  input  alu_code_e alu_code,
  input  xlen_t     npc_op1,
  input  xlen_t     npc_op2,
  input  logic      is_branch,
  input  logic      br_taken,
  output logic      redirect_req,
  output xlen_t     target_pc
);

  logic  is_jump;
  xlen_t target_sum;

  assign is_jump    = (alu_code == ALU_JAL) || (alu_code == ALU_JALR);
  assign target_sum = npc_op1 + npc_op2;

  // leave the sequential path on any jump or a taken branch
  assign redirect_req = is_jump || (is_branch && br_taken);

  // ==============================
  // target
  // ==============================
  always_comb begin
    target_pc = '0;  // quiet when not redirecting
    if (redirect_req) begin
      target_pc = target_sum;
      if (alu_code == ALU_JALR) begin
        target_pc[0] = 1'b0;
      end
    end
  end

endmodule

//--- design/exe_mem_reg.sv
module exe_mem_reg import exec_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  dec_exe_t   dec,
  input  xlen_t      alu_result,
  input  mem_width_e mem_width,
  input  logic       is_load_unsigned,
  input  logic       redirect_req,
  input  xlen_t      target_pc,
  output exe_mem_t   mem,
  output logic       redirect,
  output xlen_t      redirect_pc
);

  // ==============================
  // execute -> memory register
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem         <= '0;  // write enable, load and store flags all off
      redirect    <= 1'b0;
      redirect_pc <= '0;
    end else begin
      mem.pc               <= dec.pc;
      mem.alu_result       <= alu_result;
      mem.w_data           <= dec.rs2_data;  // store data
      mem.mem_width        <= mem_width;
      mem.rd_ctrl          <= dec.rd_ctrl;
      mem.is_load          <= dec.is_load;
      mem.is_store         <= dec.is_store;
      mem.is_load_unsigned <= is_load_unsigned;
      redirect             <= redirect_req;  // one-cycle strobe
      redirect_pc          <= target_pc;
    end
  end

  // ==============================
  // checks
  // ==============================

  // decode must never mark one instruction as both load and store
  a_ld_st_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(mem.is_load && mem.is_store)
  ) else $error("is_load and is_store both set");

  // misaligned targets are flagged here, fetch does not correct them
  a_target_align: assert property (
    @(posedge clk) disable iff (!rst_n)
    redirect |-> (redirect_pc[1:0] == 2'b00)
  ) else $error("redirect_pc %h not word aligned", redirect_pc);

endmodule

//--- design/execute_stage.sv
module execute_stage import exec_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  dec_exe_t dec,
  output exe_mem_t mem,
  output logic     redirect,
  output xlen_t    redirect_pc
);

  xlen_t      alu_op1;
  xlen_t      alu_op2;
  xlen_t      npc_op1;
  xlen_t      npc_op2;
  xlen_t      alu_result;
  logic       is_branch;
  logic       br_taken;
  mem_width_e mem_width;
  logic       is_load_unsigned;
  logic       redirect_req;
  xlen_t      target_pc;

  operand_select u_operand_select (
    .ctrl    (dec.alu_ctrl),
    .pc      (dec.pc),
    .rs1     (dec.rs1_data),
    .rs2     (dec.rs2_data),
    .imm     (dec.imm),
    .alu_op1 (alu_op1),
    .alu_op2 (alu_op2),
    .npc_op1 (npc_op1),
    .npc_op2 (npc_op2)
  );

  alu u_alu (
    .alu_code         (dec.alu_ctrl.alu_code),
    .op1              (alu_op1),
    .op2              (alu_op2),
    .pc               (dec.pc),
    .alu_result       (alu_result),
    .is_branch        (is_branch),
    .br_taken         (br_taken),
    .mem_width        (mem_width),
    .is_load_unsigned (is_load_unsigned)
  );

  branch_unit u_branch_unit (
    .alu_code     (dec.alu_ctrl.alu_code),
    .npc_op1      (npc_op1),
    .npc_op2      (npc_op2),
    .is_branch    (is_branch),
    .br_taken     (br_taken),
    .redirect_req (redirect_req),
    .target_pc    (target_pc)
  );

  exe_mem_reg u_exe_mem_reg (
    .clk              (clk),
    .rst_n            (rst_n),
    .dec              (dec),
    .alu_result       (alu_result),
    .mem_width        (mem_width),
    .is_load_unsigned (is_load_unsigned),
    .redirect_req     (redirect_req),
    .target_pc        (target_pc),
    .mem              (mem),
    .redirect         (redirect),
    .redirect_pc      (redirect_pc)
  );

endmodule

//--- tb/execute_stage_tb.sv
module execute_stage_tb import exec_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          CLK_HALF      = 50;  // 100 ns period
  localparam int          RESET_CYCLES  = 8;
  localparam int          RESET_TIMEOUT = 20;
  localparam int          SAMPLE_DLY    = 5;
  localparam int          DRIVE_DLY     = 10;
  localparam int          NUM_RANDOM    = 200;
  localparam logic [31:0] LFSR_SEED     = 32'h6b73_6a2f;
  localparam logic [31:0] LFSR_TAPS     = 32'h8020_0003;

  typedef struct packed {
    dec_exe_t   dec;
    xlen_t      result;
    mem_width_e width;
    logic       ld_unsigned;
    logic       redir;
    xlen_t      redir_pc;
  } vec_t;

  logic        clk;
  logic        rst_n;
  dec_exe_t    dec;
  exe_mem_t    mem;
  logic        redirect;
  xlen_t       redirect_pc;

  vec_t        vecs[$];
  int          errors;
  int          checks;
  logic [31:0] lfsr_state;

  execute_stage DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .dec         (dec),
    .mem         (mem),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    dec   = '0;  // idle slot on the first edge out of reset
  end

  // ==============================
  // helpers
  // ==============================
  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
      val = {val[30:0], lfsr_state[0]};  // one step per bit
    end
    return val;
  endfunction

  function automatic logic branch_code(alu_code_e code);
    return (code == ALU_BEQ) || (code == ALU_BNE) || (code == ALU_BLT) ||
           (code == ALU_BGE) || (code == ALU_BLTU) || (code == ALU_BGEU);
  endfunction

  function automatic logic load_code(alu_code_e code);
    return (code == ALU_LB) || (code == ALU_LH) || (code == ALU_LW) ||
           (code == ALU_LBU) || (code == ALU_LHU);
  endfunction

  function automatic logic store_code(alu_code_e code);
    return (code == ALU_SB) || (code == ALU_SH) || (code == ALU_SW);
  endfunction

  function automatic dec_exe_t build_dec(alu_code_e code, op1_sel_e s1, op2_sel_e s2,
                                         xlen_t pc, xlen_t rs1, xlen_t rs2, xlen_t imm,
                                         reg_addr_t rd);
    dec_exe_t d;
    d = '0;
    d.pc                = pc;
    d.rs1_data          = rs1;
    d.rs2_data          = rs2;
    d.imm               = imm;
    d.alu_ctrl.alu_code = code;
    d.alu_ctrl.op1_sel  = s1;
    d.alu_ctrl.op2_sel  = s2;
    d.rd_ctrl.we        = !(branch_code(code) || store_code(code));
    d.rd_ctrl.addr      = rd;
    d.is_load           = load_code(code);
    d.is_store          = store_code(code);
    return d;
  endfunction

  // expected results from the RV32I rules of the execute stage
  function automatic vec_t ref_model(dec_exe_t d);
    vec_t        v;
    xlen_t       a;
    xlen_t       b;
    logic [63:0] ext;
    alu_code_e   code;
    code    = d.alu_ctrl.alu_code;
    v       = '0;
    v.dec   = d;
    v.width = MEM_WORD;
    if (branch_code(code)) begin
      a = d.rs1_data;
      b = d.rs2_data;
    end else begin
      case (d.alu_ctrl.op1_sel)
        OP1_RS1: a = d.rs1_data;
        OP1_PC:  a = d.pc;
        default: a = '0;
      endcase
      b = (d.alu_ctrl.op2_sel == OP2_IMM) ? d.imm : d.rs2_data;
    end
    case (code)
      ALU_ADD:  v.result = a + b;
      ALU_SUB:  v.result = a - b;
      ALU_SLT:  v.result = {31'd0, $signed(a) < $signed(b)};
      ALU_SLTU: v.result = {31'd0, a < b};
      ALU_XOR:  v.result = a ^ b;
      ALU_OR:   v.result = a | b;
      ALU_AND:  v.result = a & b;
      ALU_SLL:  v.result = a << b[4:0];
      ALU_SRL:  v.result = a >> b[4:0];
      ALU_SRA: begin
        ext      = {{32{a[31]}}, a} >> b[4:0];  // sign fill from the upper word
        v.result = ext[31:0];
      end
      ALU_LUI:  v.result = b;
      ALU_BEQ:  v.redir = (a == b);
      ALU_BNE:  v.redir = (a != b);
      ALU_BLT:  v.redir = $signed(a) < $signed(b);
      ALU_BGE:  v.redir = $signed(a) >= $signed(b);
      ALU_BLTU: v.redir = a < b;
      ALU_BGEU: v.redir = a >= b;
      ALU_JAL, ALU_JALR: begin
        v.result = d.pc + PC_STEP;
        v.redir  = 1'b1;
      end
      ALU_LB, ALU_LBU, ALU_SB: begin
        v.result = a + b;
        v.width  = MEM_BYTE;
      end
      ALU_LH, ALU_LHU, ALU_SH: begin
        v.result = a + b;
        v.width  = MEM_HALF;
      end
      ALU_LW, ALU_SW: v.result = a + b;
      default: v.result = '0;
    endcase
    v.ld_unsigned = (code == ALU_LBU) || (code == ALU_LHU);
    if (v.redir) begin
      v.redir_pc = (code == ALU_JALR) ? ((d.rs1_data + d.imm) & ~32'd1) : (d.pc + d.imm);
    end
    return v;
  endfunction

  function automatic dec_exe_t random_dec();
    logic [31:0] r;
    logic [4:0]  c;
    alu_code_e   code;
    op1_sel_e    s1;
    op2_sel_e    s2;
    xlen_t       pc;
    xlen_t       rs1;
    xlen_t       rs2;
    xlen_t       imm;
    r = rand_bits(5);
    c = r[4:0];
    if (c > 5'd26) begin
      c = c - 5'd16;  // fold unused codes back onto branches
    end
    code = alu_code_e'(c);
    r    = rand_bits(2);
    s1   = (r[1:0] == 2'd3) ? OP1_RS1 : op1_sel_e'(r[1:0]);
    r    = rand_bits(1);
    s2   = op2_sel_e'(r[0]);
    pc   = rand_bits(32) & ~32'd3;
    rs1  = rand_bits(32);
    rs2  = rand_bits(32);
    imm  = rand_bits(32) & ~32'd3;  // word aligned targets
    if (code == ALU_JALR) begin
      rs1[1] = 1'b0;  // jalr clears bit 0 itself
    end
    r = rand_bits(5);
    return build_dec(code, s1, s2, pc, rs1, rs2, imm, r[4:0]);
  endfunction

  // ==============================
  // vector table
  // ==============================
  task automatic row(alu_code_e code, int s1, int s2, xlen_t pc, xlen_t rs1, xlen_t rs2,
                     xlen_t imm, xlen_t res, int w, int uns, int redir, xlen_t rpc);
    vec_t v;
    v             = '0;
    v.dec         = build_dec(code, op1_sel_e'(s1[1:0]), op2_sel_e'(s2[0]), pc, rs1, rs2,
                              imm, reg_addr_t'(vecs.size()));
    v.result      = res;
    v.width       = mem_width_e'(w[1:0]);
    v.ld_unsigned = (uns != 0);
    v.redir       = (redir != 0);
    v.redir_pc    = rpc;
    vecs.push_back(v);
  endtask

  task automatic load_table();
    // code, op1 sel, op2 sel, pc, rs1, rs2, imm, result, width, unsigned, redirect, target
    row(ALU_ADD,  0, 0, 'h100, 'h00000005, 'h00000007, 'h0, 'h0000000c, 2, 0, 0, 'h0);
    row(ALU_ADD,  0, 1, 'h104, 'h7fffffff, 'h00001234, 'h1, 'h80000000, 2, 0, 0, 'h0);
    row(ALU_SUB,  0, 0, 'h108, 'h00000000, 'h00000001, 'h0, 'hffffffff, 2, 0, 0, 'h0);
    row(ALU_SUB,  0, 0, 'h10c, 'h80000000, 'h00000001, 'h0, 'h7fffffff, 2, 0, 0, 'h0);
    row(ALU_SLT,  0, 0, 'h110, 'hffffffff, 'h00000001, 'h0, 'h00000001, 2, 0, 0, 'h0);
    row(ALU_SLTU, 0, 0, 'h114, 'hffffffff, 'h00000001, 'h0, 'h00000000, 2, 0, 0, 'h0);
    row(ALU_SLT,  0, 0, 'h118, 'h00000001, 'h80000000, 'h0, 'h00000000, 2, 0, 0, 'h0);
    row(ALU_SLTU, 0, 0, 'h11c, 'h00000001, 'h80000000, 'h0, 'h00000001, 2, 0, 0, 'h0);
    row(ALU_XOR,  0, 0, 'h120, 'hf0f0f0f0, 'hff00ff00, 'h0, 'h0ff00ff0, 2, 0, 0, 'h0);
    row(ALU_OR,   0, 0, 'h124, 'hf0f0f0f0, 'h0f000000, 'h0, 'hfff0f0f0, 2, 0, 0, 'h0);
    row(ALU_AND,  0, 0, 'h128, 'hf0f0f0f0, 'hff00ff00, 'h0, 'hf000f000, 2, 0, 0, 'h0);
    row(ALU_SLL,  0, 0, 'h12c, 'h00000001, 'h00000024, 'h0, 'h00000010, 2, 0, 0, 'h0);
    row(ALU_SRL,  0, 0, 'h130, 'h80000000, 'h0000003f, 'h0, 'h00000001, 2, 0, 0, 'h0);
    row(ALU_SRA,  0, 0, 'h134, 'h80000000, 'h00000004, 'h0, 'hf8000000, 2, 0, 0, 'h0);
    row(ALU_SRA,  0, 0, 'h138, 'hfffffff0, 'h00000021, 'h0, 'hfffffff8, 2, 0, 0, 'h0);
    row(ALU_LUI,  2, 1, 'h13c, 'hdeadbeef, 'h0, 'h12345000, 'h12345000, 2, 0, 0, 'h0);
    row(ALU_ADD,  1, 1, 'h2000, 'h0, 'h0, 'h1000, 'h00003000, 2, 0, 0, 'h0);
    // branches ignore the operand selects
    row(ALU_BEQ,  1, 1, 'h1000, 'h5, 'h5, 'h40, 'h0, 2, 0, 1, 'h1040);
    row(ALU_BEQ,  0, 0, 'h1000, 'h5, 'h6, 'h40, 'h0, 2, 0, 0, 'h0);
    row(ALU_BNE,  0, 0, 'h1000, 'h5, 'h6, 'hfffffff0, 'h0, 2, 0, 1, 'h0ff0);
    row(ALU_BNE,  0, 0, 'h1000, 'h7, 'h7, 'h40, 'h0, 2, 0, 0, 'h0);
    row(ALU_BLT,  0, 0, 'h1000, 'hffffffff, 'h1, 'h40, 'h0, 2, 0, 1, 'h1040);
    row(ALU_BLT,  0, 0, 'h1000, 'h1, 'hffffffff, 'h40, 'h0, 2, 0, 0, 'h0);
    row(ALU_BGE,  0, 0, 'h1000, 'h1, 'hffffffff, 'h40, 'h0, 2, 0, 1, 'h1040);
    row(ALU_BGE,  0, 0, 'h1000, 'h80000000, 'h0, 'h40, 'h0, 2, 0, 0, 'h0);
    row(ALU_BLTU, 0, 0, 'h1000, 'h1, 'hffffffff, 'h40, 'h0, 2, 0, 1, 'h1040);
    row(ALU_BLTU, 0, 0, 'h1000, 'hffffffff, 'h1, 'h40, 'h0, 2, 0, 0, 'h0);
    row(ALU_BGEU, 1, 1, 'h1000, 'hffffffff, 'h1, 'h40, 'h0, 2, 0, 1, 'h1040);
    row(ALU_BGEU, 0, 0, 'h1000, 'h0, 'h1, 'h40, 'h0, 2, 0, 0, 'h0);
    // jumps
    row(ALU_JAL,  1, 1, 'h3000, 'h0, 'h0, 'h100, 'h3004, 2, 0, 1, 'h3100);
    row(ALU_JAL,  1, 1, 'h3000, 'h0, 'h0, 'hfffff000, 'h3004, 2, 0, 1, 'h2000);
    row(ALU_JALR, 0, 1, 'h400, 'h1001, 'h0, 'h0, 'h404, 2, 0, 1, 'h1000);
    row(ALU_JALR, 0, 1, 'h500, 'h2000, 'h0, 'h11, 'h504, 2, 0, 1, 'h2010);
    // loads and stores
    row(ALU_LB,   0, 1, 'h600, 'h1000, 'haaaa5555, 'h3, 'h1003, 0, 0, 0, 'h0);
    row(ALU_LH,   0, 1, 'h604, 'h1000, 'h0, 'hfffffffe, 'h0ffe, 1, 0, 0, 'h0);
    row(ALU_LW,   0, 1, 'h608, 'h2000, 'h0, 'h10, 'h2010, 2, 0, 0, 'h0);
    row(ALU_LBU,  0, 1, 'h60c, 'h3000, 'h0, 'h1, 'h3001, 0, 1, 0, 'h0);
    row(ALU_LHU,  0, 1, 'h610, 'h3000, 'h0, 'h2, 'h3002, 1, 1, 0, 'h0);
    row(ALU_SB,   0, 1, 'h614, 'h4000, 'h000000ab, 'h5, 'h4005, 0, 0, 0, 'h0);
    row(ALU_SH,   0, 1, 'h618, 'h4000, 'h0000beef, 'h6, 'h4006, 1, 0, 0, 'h0);
    row(ALU_SW,   0, 1, 'h61c, 'h4000, 'hcafef00d, 'h8, 'h4008, 2, 0, 0, 'h0);
  endtask

  // ==============================
  // sequencing
  // ==============================
  task automatic check_outputs(vec_t v);
    check_value("mem.alu_result", mem.alu_result, v.result);
    check_value("mem.mem_width", 32'(mem.mem_width), 32'(v.width));
    check_value("mem.is_load_unsigned", 32'(mem.is_load_unsigned), 32'(v.ld_unsigned));
    check_value("redirect", 32'(redirect), 32'(v.redir));
    check_value("redirect_pc", redirect_pc, v.redir_pc);
    check_value("mem.pc", mem.pc, v.dec.pc);
    check_value("mem.w_data", mem.w_data, v.dec.rs2_data);
    check_value("mem.rd_ctrl", 32'(mem.rd_ctrl), 32'(v.dec.rd_ctrl));
    check_value("mem.is_load", 32'(mem.is_load), 32'(v.dec.is_load));
    check_value("mem.is_store", 32'(mem.is_store), 32'(v.dec.is_store));
  endtask

  // check what was captured on this edge, then drive the next instruction
  task automatic step(input vec_t next, inout vec_t pending);
    @(posedge clk);
    #SAMPLE_DLY;
    check_outputs(pending);
    #(DRIVE_DLY - SAMPLE_DLY);
    dec     = next.dec;
    pending = next;
  endtask

  task automatic wait_reset(output logic ok);
    int cycles;
    ok     = 1'b0;
    cycles = 0;
    while (!ok && cycles < RESET_TIMEOUT) begin
      @(posedge clk);
      #SAMPLE_DLY;
      check_value("mem.rd_ctrl.we", 32'(mem.rd_ctrl.we), 32'd0);
      check_value("mem.is_load", 32'(mem.is_load), 32'd0);
      check_value("mem.is_store", 32'(mem.is_store), 32'd0);
      check_value("redirect", 32'(redirect), 32'd0);
      cycles++;
      if (rst_n) begin
        ok = 1'b1;
      end
    end
  endtask

  initial begin
    logic reset_ok;
    vec_t pending;
    errors       = 0;
    checks       = 0;
    lfsr_state   = LFSR_SEED;
    dec          = build_dec(ALU_JAL, OP1_PC, OP2_IMM, 32'h80, '0, '0, 32'h10, 5'd1);
    dec.is_load  = 1'b1;  // every flag busy while reset holds the outputs
    dec.is_store = 1'b1;
    load_table();
    wait_reset(reset_ok);
    if (!reset_ok) begin
      $display("reset was not released within %0d cycles", RESET_TIMEOUT);
      $display("Simulation failed");
      $finish;
    end else begin
      #(DRIVE_DLY - SAMPLE_DLY);
      pending = vecs[0];
      dec     = pending.dec;
      for (int i = 1; i < vecs.size(); i++) begin
        step(vecs[i], pending);
      end
      for (int n = 0; n < NUM_RANDOM; n++) begin
        step(ref_model(random_dec()), pending);
      end
      step(ref_model('0), pending);  // idle slot flushes the last one
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
        $display("Simulation passed");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule

//--- sim.f
design/exec_pkg.sv
design/operand_select.sv
design/alu.sv
design/branch_unit.sv
design/exe_mem_reg.sv
design/execute_stage.sv
tb/execute_stage_tb.sv

//--- Makefile
TOP   = execute_stage_tb
BUILD = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build sim.f with Verilator, run it into sim.log and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -Mdir $(BUILD) -o sim -f sim.f
	./$(BUILD)/sim > sim.log 2>&1; cat sim.log
	@if grep -q "Simulation failed" sim.log; then echo "test failed"; exit 1; fi
	@if ! grep -q "Simulation passed" sim.log; then echo "run did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD) sim.log
